// ==== flist.f ====
lcd_pkg.sv
lcd_timing.sv
tile_loader.sv
video_ram.sv
pixel_mux.sv
lcd_tile_display.sv
tb_lcd_tile_display.sv

// ==== lcd_pkg.sv ====
package lcd_pkg;

	// x and y counters are wide enough for the whole frame
	localparam int cnt_w = 16;

	// horizontal timing in pixels
	localparam logic [cnt_w-1:0] h_active = 16'd480;
	localparam logic [cnt_w-1:0] h_front = 16'd8;
	localparam logic [cnt_w-1:0] h_sync = 16'd4;
	localparam logic [cnt_w-1:0] h_back = 16'd39;
	localparam logic [cnt_w-1:0] h_total = h_active + h_front + h_sync + h_back;

	// vertical timing in lines
	localparam logic [cnt_w-1:0] v_active = 16'd272;
	localparam logic [cnt_w-1:0] v_front = 16'd4;
	localparam logic [cnt_w-1:0] v_sync = 16'd4;
	localparam logic [cnt_w-1:0] v_back = 16'd8;
	localparam logic [cnt_w-1:0] v_total = v_active + v_front + v_sync + v_back;

	// top-left corner and size of the tile window in pixels
	localparam logic [cnt_w-1:0] win_x0 = 16'd112;
	localparam logic [cnt_w-1:0] win_y0 = 16'd72;
	localparam logic [cnt_w-1:0] win_w = 16'd256;
	localparam logic [cnt_w-1:0] win_h = 16'd128;

	localparam int tile_shift = 2; // 4x4 pixels per tile

	// the window is 64 tiles across and 32 tiles down
	localparam int tile_col_w = 6;
	localparam int tile_row_w = 5;

	// video memory geometry
	localparam int addr_w = 11;
	localparam int data_w = 8;
	localparam int bank_count = 4;
	localparam int bank_sel_w = 2; // top address bits pick the bank
	localparam int bank_addr_w = 9;

	// writes held back while the panel is in active video
	localparam int pend_depth = 8;
	localparam int pend_ptr_w = 3;

endpackage

// ==== lcd_testdata.txt ====
# L addr data in hex loads a tile in the first vertical blanking
# W frame x y addr data drives one write when output pixel x,y of that frame is shown
# S frame x y red green blue is the expected colour of one output pixel
L 000 3f
L 03f 25
L 24a 5a
L 45f c7
L 7e0 81
L 505 14
L 328 6e
L 200 09
W 1 100 153 505 33
W 1 101 153 294 a2
W 2 200 60 080 11
W 2 201 60 0c1 22
W 2 202 60 2c2 33
W 2 203 60 303 44
W 2 204 60 484 55
W 2 205 60 4c5 66
W 2 206 60 686 77
W 2 207 60 7c7 88
W 2 208 60 328 ff
S 1 111 100 19 6 0
S 1 113 73 31 63 31
S 1 367 75 5 37 5
S 1 368 72 24 13 0
S 1 153 109 26 26 26
S 1 114 105 9 9 9
S 1 236 140 7 7 7
S 1 134 153 20 20 20
S 1 133 154 19 51 19
S 1 243 199 1 1 1
S 1 479 271 14 23 0
S 2 113 81 17 17 17
S 2 117 85 2 34 2
S 2 192 113 2 34 2
S 2 121 117 19 51 19
S 2 124 120 4 4 4
S 2 273 121 14 46 14
S 2 130 146 21 21 21
S 2 133 149 6 38 6
S 2 138 177 23 55 23
S 2 141 198 8 8 8

// ==== lcd_tile_display.sv ====
`timescale 1ns/1ps

module lcd_tile_display (
	input  logic                       pixel_clk,
	input  logic                       rst,
	input  logic                       load_we,
	input  logic [lcd_pkg::addr_w-1:0] load_addr,
	input  logic [lcd_pkg::data_w-1:0] load_data,
	output logic                       lcd_hsync,
	output logic                       lcd_vsync,
	output logic                       lcd_den,
	output logic [4:0]                 lcd_r,
	output logic [5:0]                 lcd_g,
	output logic [4:0]                 lcd_b,
	output logic                       load_overflow
);

	logic [lcd_pkg::cnt_w-1:0] x;
	logic [lcd_pkg::cnt_w-1:0] y;
	logic                      den_raw;
	logic                      hsync_raw;
	logic                      vsync_raw;

	logic [lcd_pkg::bank_addr_w-1:0] wr_addr;
	logic [lcd_pkg::data_w-1:0]      wr_data;
	logic [lcd_pkg::bank_count-1:0]  bank_we;
	logic [lcd_pkg::bank_addr_w-1:0] rd_addr;

	logic [lcd_pkg::bank_count-1:0][lcd_pkg::data_w-1:0] bank_data;

	lcd_timing timing (
		.pixel_clk (pixel_clk),
		.rst       (rst),
		.x         (x),
		.y         (y),
		.den_raw   (den_raw),
		.hsync_raw (hsync_raw),
		.vsync_raw (vsync_raw)
	);

	tile_loader loader (
		.pixel_clk     (pixel_clk),
		.rst           (rst),
		.den_raw       (den_raw),
		.load_we       (load_we),
		.load_addr     (load_addr),
		.load_data     (load_data),
		.wr_addr       (wr_addr),
		.wr_data       (wr_data),
		.bank_we       (bank_we),
		.load_overflow (load_overflow)
	);

	// every bank sees the same addresses, only its write enable differs
	for (genvar i = 0; i < lcd_pkg::bank_count; i++) begin : gen_bank
		video_ram vmem (
			.pixel_clk (pixel_clk),
			.we        (bank_we[i]),
			.addr_wr   (wr_addr),
			.data_wr   (wr_data),
			.addr_rd   (rd_addr),
			.data_rd   (bank_data[i])
		);
	end

	pixel_mux mux (
		.pixel_clk (pixel_clk),
		.rst       (rst),
		.x         (x),
		.y         (y),
		.den_raw   (den_raw),
		.hsync_raw (hsync_raw),
		.vsync_raw (vsync_raw),
		.bank_data (bank_data),
		.rd_addr   (rd_addr),
		.lcd_hsync (lcd_hsync),
		.lcd_vsync (lcd_vsync),
		.lcd_den   (lcd_den),
		.lcd_r     (lcd_r),
		.lcd_g     (lcd_g),
		.lcd_b     (lcd_b)
	);

endmodule

// ==== lcd_timing.sv ====
`timescale 1ns/1ps

module lcd_timing (
	input  logic                       pixel_clk,
	input  logic                       rst,
	output logic [lcd_pkg::cnt_w-1:0]  x,
	output logic [lcd_pkg::cnt_w-1:0]  y,
	output logic                       den_raw,
	output logic                       hsync_raw,
	output logic                       vsync_raw
);

	logic x_last;
	logic y_last;
	logic h_in_sync;
	logic v_in_sync;

	assign x_last = (x == lcd_pkg::h_total - 1'b1);
	assign y_last = (y == lcd_pkg::v_total - 1'b1);

	// pixel counter wraps at the end of each line
	always_ff @(posedge pixel_clk or negedge rst) begin
		if (!rst) begin
			x <= '0;
		end else if (x_last) begin
			x <= '0;
		end else begin
			x <= x + 1'b1;
		end
	end

	// line counter only moves on the last pixel of a line
	always_ff @(posedge pixel_clk or negedge rst) begin
		if (!rst) begin
			y <= '0;
		end else if (x_last) begin
			if (y_last) begin
				y <= '0;
			end else begin
				y <= y + 1'b1;
			end
		end
	end

	// sync pulse sits between the front and back porch
	assign h_in_sync = (x >= lcd_pkg::h_active + lcd_pkg::h_front) &&
		(x < lcd_pkg::h_active + lcd_pkg::h_front + lcd_pkg::h_sync);
	assign v_in_sync = (y >= lcd_pkg::v_active + lcd_pkg::v_front) &&
		(y < lcd_pkg::v_active + lcd_pkg::v_front + lcd_pkg::v_sync);

	assign hsync_raw = !h_in_sync; // both syncs are active low
	assign vsync_raw = !v_in_sync;

	assign den_raw = (x < lcd_pkg::h_active) && (y < lcd_pkg::v_active);

endmodule

// ==== pixel_mux.sv ====
`timescale 1ns/1ps

module pixel_mux (
	input  logic                                              pixel_clk,
	input  logic                                              rst,
	input  logic [lcd_pkg::cnt_w-1:0]                         x,
	input  logic [lcd_pkg::cnt_w-1:0]                         y,
	input  logic                                              den_raw,
	input  logic                                              hsync_raw,
	input  logic                                              vsync_raw,
	input  logic [lcd_pkg::bank_count-1:0][lcd_pkg::data_w-1:0] bank_data,
	output logic [lcd_pkg::bank_addr_w-1:0]                   rd_addr,
	output logic                                              lcd_hsync,
	output logic                                              lcd_vsync,
	output logic                                              lcd_den,
	output logic [4:0]                                        lcd_r,
	output logic [5:0]                                        lcd_g,
	output logic [4:0]                                        lcd_b
);

	logic [lcd_pkg::cnt_w-1:0]      rel_x;
	logic [lcd_pkg::cnt_w-1:0]      rel_y;
	logic [lcd_pkg::addr_w-1:0]     tile_addr;
	logic                           in_win;
	logic [lcd_pkg::cnt_w-1:0]      grad;

	logic [lcd_pkg::bank_sel_w-1:0] sel_d1;
	logic                           in_win_d1;
	logic [lcd_pkg::cnt_w-1:0]      grad_d1;
	logic                           hsync_d1;
	logic                           vsync_d1;
	logic                           den_d1;
	logic [lcd_pkg::data_w-1:0]     tile_byte;

	assign rel_x = x - lcd_pkg::win_x0;
	assign rel_y = y - lcd_pkg::win_y0;

	assign in_win = (x >= lcd_pkg::win_x0) && (x < lcd_pkg::win_x0 + lcd_pkg::win_w) &&
		(y >= lcd_pkg::win_y0) && (y < lcd_pkg::win_y0 + lcd_pkg::win_h);

	// tile row sits above tile column, so the bank follows the row
	assign tile_addr = {rel_y[lcd_pkg::tile_shift +: lcd_pkg::tile_row_w],
		rel_x[lcd_pkg::tile_shift +: lcd_pkg::tile_col_w]};
	assign rd_addr = tile_addr[lcd_pkg::bank_addr_w-1:0];

	assign grad = x + y;

	// stage one lines up with the bank read latency
	always_ff @(posedge pixel_clk) begin
		sel_d1 <= tile_addr[lcd_pkg::addr_w-1 -: lcd_pkg::bank_sel_w];
		in_win_d1 <= in_win;
		grad_d1 <= grad;
	end

	always_ff @(posedge pixel_clk or negedge rst) begin
		if (!rst) begin
			hsync_d1 <= 1'b1;
			vsync_d1 <= 1'b1;
			den_d1 <= 1'b0;
		end else begin
			hsync_d1 <= hsync_raw;
			vsync_d1 <= vsync_raw;
			den_d1 <= den_raw;
		end
	end

	assign tile_byte = bank_data[sel_d1];

	always_ff @(posedge pixel_clk or negedge rst) begin
		if (!rst) begin
			lcd_hsync <= 1'b1;
			lcd_vsync <= 1'b1;
			lcd_den <= 1'b0;
			{lcd_b, lcd_g, lcd_r} <= '0;
		end else begin
			lcd_hsync <= hsync_d1;
			lcd_vsync <= vsync_d1;
			lcd_den <= den_d1;
			if (!den_d1) begin
				{lcd_b, lcd_g, lcd_r} <= '0; // panel expects black in blanking
			end else if (in_win_d1) begin
				{lcd_b, lcd_g, lcd_r} <= {tile_byte[4:0], tile_byte[5:0], tile_byte[4:0]};
			end else begin
				{lcd_b, lcd_g, lcd_r} <= grad_d1;
			end
		end
	end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal -f flist.f \
	--top-module tb_lcd_tile_display -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

./obj_dir/Vtb_lcd_tile_display > "$log" 2>&1
status=$?
cat "$log"

if grep -q "TEST FAIL" "$log"; then
	echo "simulation reported a failure, see $log"
	exit 1
fi

if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if ! grep -q "TEST PASS" "$log"; then
	echo "simulation ended without a result"
	exit 1
fi

echo "simulation passed"
exit 0

// ==== tb_lcd_tile_display.sv ====
`timescale 1ns/1ps

module tb_lcd_tile_display;

	typedef struct packed {
		int frame;
		int px;
		int py;
		int r;
		int g;
		int b;
	} sample_t;

	typedef struct packed {
		int frame;
		int px;
		int py;
		int addr;
		int data;
	} write_t;

	logic                       pixel_clk;
	logic                       rst;
	logic                       load_we;
	logic [lcd_pkg::addr_w-1:0] load_addr;
	logic [lcd_pkg::data_w-1:0] load_data;
	logic                       lcd_hsync;
	logic                       lcd_vsync;
	logic                       lcd_den;
	logic [4:0]                 lcd_r;
	logic [5:0]                 lcd_g;
	logic [4:0]                 lcd_b;
	logic                       load_overflow;

	sample_t samples[$];
	write_t  strobes[$]; // writes driven while the panel is in active video
	write_t  loads[$];

	int   cycle;
	int   timeout_limit;
	int   frame;
	int   ox;
	int   oy;
	int   samples_done;
	int   strobes_done;
	int   hs_last;
	int   vs_last;
	logic hs_prev;
	logic vs_prev;
	logic den_prev;

	lcd_tile_display dut (
		.pixel_clk     (pixel_clk),
		.rst           (rst),
		.load_we       (load_we),
		.load_addr     (load_addr),
		.load_data     (load_data),
		.lcd_hsync     (lcd_hsync),
		.lcd_vsync     (lcd_vsync),
		.lcd_den       (lcd_den),
		.lcd_r         (lcd_r),
		.lcd_g         (lcd_g),
		.lcd_b         (lcd_b),
		.load_overflow (load_overflow)
	);

	always #20 pixel_clk = ~pixel_clk;

	task automatic stop_with(input string why);
		$display("%s", why);
		$display("TEST FAIL");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input int expected, input int actual);
		assert (expected == actual) else begin
			$display("[ERROR] %s expected %0d actual %0d", name, expected, actual);
			$display("TEST FAIL");
			$fatal(1);
		end
	endtask

	task automatic read_testdata();
		int         fd;
		int         code;
		int         want;
		int         f;
		int         px;
		int         py;
		int         a;
		int         d;
		int         r;
		int         g;
		int         b;
		logic [7:0] kind;
		fd = $fopen("lcd_testdata.txt", "r");
		if (fd == 0) begin
			stop_with("could not open lcd_testdata.txt");
		end
		code = $fscanf(fd, " %c", kind);
		while (code == 1) begin
			want = 0;
			if (kind == "#") begin
				while (code == 1 && kind != 8'h0a) begin
					code = $fscanf(fd, "%c", kind);
				end
			end else if (kind == "L") begin
				code = $fscanf(fd, "%h %h", a, d);
				want = 2;
				loads.push_back('{frame: 1, px: 0, py: 0, addr: a, data: d});
			end else if (kind == "W") begin
				code = $fscanf(fd, "%d %d %d %h %h", f, px, py, a, d);
				want = 5;
				strobes.push_back('{frame: f, px: px, py: py, addr: a, data: d});
			end else if (kind == "S") begin
				code = $fscanf(fd, "%d %d %d %d %d %d", f, px, py, r, g, b);
				want = 6;
				samples.push_back('{frame: f, px: px, py: py, r: r, g: g, b: b});
			end else begin
				stop_with("unknown record type in lcd_testdata.txt");
			end
			if (want != 0 && code != want) begin
				stop_with("incomplete record in lcd_testdata.txt");
			end
			code = $fscanf(fd, " %c", kind);
		end
		$fclose(fd);
	endtask

	task automatic check_idle(input string phase);
		check_value({"den ", phase}, 0, int'(lcd_den));
		check_value({"hsync ", phase}, 1, int'(lcd_hsync));
		check_value({"vsync ", phase}, 1, int'(lcd_vsync));
		check_value({"colour ", phase}, 0, int'({lcd_r, lcd_g, lcd_b}));
		check_value({"load_overflow ", phase}, 0, int'(load_overflow));
	endtask

	// ox and oy follow the output pixel, so they trail the DUT counters
	task automatic watch_cycle();
		int i;
		cycle++;
		if (cycle > timeout_limit) begin
			stop_with("simulation timed out before the third frame began");
		end
		load_we = 1'b0;
		if (hs_prev && !lcd_hsync) begin
			if (hs_last >= 0) begin
				check_value("hsync period", int'(lcd_pkg::h_total), cycle - hs_last);
			end
			hs_last = cycle;
		end
		if (vs_prev && !lcd_vsync) begin
			if (vs_last >= 0) begin
				check_value("vsync period",
					int'(lcd_pkg::h_total) * int'(lcd_pkg::v_total), cycle - vs_last);
			end
			vs_last = cycle;
			check_value("lines with den per frame", int'(lcd_pkg::v_active), oy);
			frame++;
			// the overflow burst sits in frame 2
			check_value("load_overflow at frame start", (frame == 3) ? 1 : 0,
				int'(load_overflow));
			ox = 0;
			oy = 0;
		end
		if (lcd_den) begin
			for (i = 0; i < samples.size(); i++) begin
				if (samples[i].frame == frame && samples[i].px == ox && samples[i].py == oy) begin
					check_value($sformatf("pixel %0d,%0d frame %0d red", ox, oy, frame),
						samples[i].r, int'(lcd_r));
					check_value($sformatf("pixel %0d,%0d frame %0d green", ox, oy, frame),
						samples[i].g, int'(lcd_g));
					check_value($sformatf("pixel %0d,%0d frame %0d blue", ox, oy, frame),
						samples[i].b, int'(lcd_b));
					samples_done++;
				end
			end
			for (i = 0; i < strobes.size(); i++) begin
				if (strobes[i].frame == frame && strobes[i].px == ox && strobes[i].py == oy) begin
					load_we = 1'b1;
					load_addr = strobes[i].addr[lcd_pkg::addr_w-1:0];
					load_data = strobes[i].data[lcd_pkg::data_w-1:0];
					strobes_done++;
				end
			end
			ox++;
		end else begin
			check_value("colour while den is low", 0, int'({lcd_r, lcd_g, lcd_b}));
			if (den_prev) begin
				check_value("den cycles per line", int'(lcd_pkg::h_active), ox);
				ox = 0;
				oy++;
			end
			if (frame == 1 && loads.size() > 0) begin
				load_we = 1'b1; // one per cycle in the first vertical blanking
				load_addr = loads[0].addr[lcd_pkg::addr_w-1:0];
				load_data = loads[0].data[lcd_pkg::data_w-1:0];
				void'(loads.pop_front());
			end
		end
		hs_prev = lcd_hsync;
		vs_prev = lcd_vsync;
		den_prev = lcd_den;
	endtask

	initial begin
		pixel_clk = 1'b0;
		rst = 1'b0;
		load_we = 1'b0;
		load_addr = '0;
		load_data = '0;
		cycle = 0;
		frame = 0;
		ox = 0;
		oy = 0;
		samples_done = 0;
		strobes_done = 0;
		hs_last = -1;
		vs_last = -1;
		hs_prev = 1'b1;
		vs_prev = 1'b1;
		den_prev = 1'b0;
		timeout_limit = 4 * int'(lcd_pkg::h_total) * int'(lcd_pkg::v_total) + 1000;
		read_testdata();
		repeat (5) begin
			@(negedge pixel_clk);
			check_idle("during reset");
		end
		rst = 1'b1;
		@(negedge pixel_clk);
		check_idle("after reset");
		while (frame < 3) begin
			@(negedge pixel_clk);
			watch_cycle();
		end
		check_value("samples checked", samples.size(), samples_done);
		check_value("write strobes driven", strobes.size(), strobes_done);
		$display("TEST PASS");
		$finish;
	end

endmodule

// ==== tile_loader.sv ====
`timescale 1ns/1ps

module tile_loader (
	input  logic                           pixel_clk,
	input  logic                           rst,
	input  logic                           den_raw,
	input  logic                           load_we,
	input  logic [lcd_pkg::addr_w-1:0]     load_addr,
	input  logic [lcd_pkg::data_w-1:0]     load_data,
	output logic [lcd_pkg::bank_addr_w-1:0] wr_addr,
	output logic [lcd_pkg::data_w-1:0]     wr_data,
	output logic [lcd_pkg::bank_count-1:0] bank_we,
	output logic                           load_overflow
);

	// each entry keeps the full tile address above the byte
	logic [lcd_pkg::addr_w+lcd_pkg::data_w-1:0] pend_mem [lcd_pkg::pend_depth];

	logic [lcd_pkg::pend_ptr_w-1:0] wr_ptr;
	logic [lcd_pkg::pend_ptr_w-1:0] rd_ptr;
	logic [lcd_pkg::pend_ptr_w:0]   count;

	logic                           full;
	logic                           push;
	logic                           pop;
	logic [lcd_pkg::addr_w-1:0]     head_addr;
	logic [lcd_pkg::bank_sel_w-1:0] head_bank;

	assign full = (count == lcd_pkg::pend_depth[lcd_pkg::pend_ptr_w:0]);
	assign push = load_we && !full;
	assign pop = !den_raw && (count != '0); // memory only takes writes in blanking

	assign head_addr = pend_mem[rd_ptr][lcd_pkg::data_w +: lcd_pkg::addr_w];
	assign head_bank = head_addr[lcd_pkg::addr_w-1 -: lcd_pkg::bank_sel_w];
	assign wr_addr = head_addr[lcd_pkg::bank_addr_w-1:0];
	assign wr_data = pend_mem[rd_ptr][lcd_pkg::data_w-1:0];

	always_comb begin
		for (int i = 0; i < lcd_pkg::bank_count; i++) begin
			bank_we[i] = pop && (head_bank == i[lcd_pkg::bank_sel_w-1:0]);
		end
	end

	always_ff @(posedge pixel_clk) begin
		if (push) begin
			pend_mem[wr_ptr] <= {load_addr, load_data};
		end
	end

	// depth is a power of two so the pointers wrap by themselves
	always_ff @(posedge pixel_clk or negedge rst) begin
		if (!rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			if (push && !pop) begin
				count <= count + 1'b1;
			end else if (pop && !push) begin
				count <= count - 1'b1;
			end
		end
	end

	always_ff @(posedge pixel_clk or negedge rst) begin
		if (!rst) begin
			load_overflow <= 1'b0;
		end else if (load_we && full) begin
			load_overflow <= 1'b1; // stays up until the next reset
		end
	end

endmodule

// ==== video_ram.sv ====
`timescale 1ns/1ps

module video_ram (
	input  logic                            pixel_clk,
	input  logic                            we,
	input  logic [lcd_pkg::bank_addr_w-1:0] addr_wr,
	input  logic [lcd_pkg::data_w-1:0]      data_wr,
	input  logic [lcd_pkg::bank_addr_w-1:0] addr_rd,
	output logic [lcd_pkg::data_w-1:0]      data_rd
);

	logic [lcd_pkg::data_w-1:0] mem [2**lcd_pkg::bank_addr_w];

	logic [lcd_pkg::bank_addr_w-1:0] addr;

	// one port, so a write steals the address from the reader
	assign addr = we ? addr_wr : addr_rd;

	always_ff @(posedge pixel_clk) begin
		if (we) begin
			mem[addr] <= data_wr;
		end
		data_rd <= mem[addr]; // not looked at in a write cycle
	end

endmodule
